// ==== flist.f ====
+incdir+tb
logic/tcp_opt_pkg.sv
logic/tcp_opt_ctrl.sv
logic/opt_field_accum.sv
logic/opt_status_flags.sv
logic/opt_value_regs.sv
logic/tcp_opt_parser.sv
tb/tcp_opt_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tcp_opt_tb \
    -o tcp_opt_sim \
    && ./obj_dir/tcp_opt_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1

// ==== tb/opt_stream.svh ====
`ifndef OPT_STREAM_SVH
`define OPT_STREAM_SVH

// Expected outputs trail the driven word by one cycle
task automatic drive_word(input word_t w, input logic [2:0] p);
    @(posedge clk);
    data <= w;
    pos <= p;
    exp_out <= model;
endtask

task automatic send_idle(input int words);
    repeat (words) begin
        drive_word($urandom, 3'(4 + $urandom_range(3, 0)));
    end
endtask

// Kind, length byte, then len-2 value bytes, starting at lane p
task automatic send_option(input logic [7:0] kind, input logic [7:0] len_byte,
                           input int len, input int p, input logic [63:0] value);
    logic [7:0] seq [0:9];
    word_t      w;
    int         idx;
    bit         first;
    bit         has_len;
    seq[0] = kind;
    seq[1] = len_byte;
    for (int i = 2; i < 10; i++) begin
        seq[i] = 8'd0;
        if (i < len) begin
            seq[i] = value[8*(len - 1 - i) +: 8];
        end
    end
    idx = 0;
    first = 1'b1;
    while (idx < len) begin
        w = $urandom;
        has_len = 1'b0;
        for (int l = (first ? p : 0); l < 4; l++) begin
            if (idx < len) begin
                w[8*(3 - l) +: 8] = seq[idx];
                if (idx == 1) begin
                    has_len = 1'b1;
                end
                idx++;
            end
        end
        drive_word(w, first ? 3'(p) : 3'($urandom_range(7, 0)));
        if (!frozen) begin
            if (first) begin
                model.av[kind[3:0]] = 1'b1;
            end
            if (has_len && len_byte != 8'(len)) begin
                model.err[kind[3:0]] = 1'b1;
            end
            model.b_left = 4'(len - idx);
            if (idx == len) begin
                case (kind)
                    8'd0: frozen = 1'b1;
                    8'd2: model.mss = value[15:0];
                    8'd3: model.scale = value[7:0];
                    8'd8: model.ts = value;
                    default: begin
                    end
                endcase
            end
        end
        first = 1'b0;
    end
endtask

task automatic send_bad_length(input logic [7:0] kind, input int len,
                               input logic [63:0] value);
    logic [7:0] bad;
    bad = 8'(len);
    while (bad == 8'(len)) begin
        bad = 8'($urandom);
    end
    send_option(kind, bad, len, int'($urandom_range(3, 0)), value);
endtask

// Unknown kind locks the parser with every error bit set
task automatic send_unknown(input logic [7:0] kind, input int p);
    word_t w;
    w = $urandom;
    w[8*(3 - p) +: 8] = kind;
    drive_word(w, 3'(p));
    if (!frozen) begin
        model.err = '1;
        frozen = 1'b1;
    end
endtask

`endif

// ==== tb/tcp_opt_tb.sv ====
`timescale 1ns/10ps

module tcp_opt_tb
    import tcp_opt_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    // Upper bound on words driven by all tests and resets
    localparam int TOTAL_WORDS = 130;
    localparam int WATCHDOG_NS = (TOTAL_WORDS + 50) * CLK_PERIOD;

    typedef struct packed {
        opt_flags_t  av;
        opt_flags_t  err;
        logic [15:0] mss;
        logic [7:0]  scale;
        logic [63:0] ts;
        logic [3:0]  b_left;
    } outputs_t;

    logic        clk;
    logic        reset;
    word_t       data;
    logic [2:0]  pos;
    opt_flags_t  option_av;
    opt_flags_t  option_err;
    logic [15:0] mss;
    logic [7:0]  scale_wnd;
    logic [63:0] time_stp;
    logic [3:0]  b_left;

    // Model after the last word driven, and the copy under check
    outputs_t    model;
    outputs_t    exp_out;
    bit          frozen;
    int          av_errors;
    int          err_errors;
    int          value_errors;
    int          left_errors;

    `include "opt_stream.svh"

    tcp_opt_parser #(
        .ACC_BYTES (8)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .data       (data),
        .pos        (pos),
        .option_av  (option_av),
        .option_err (option_err),
        .mss        (mss),
        .scale_wnd  (scale_wnd),
        .time_stp   (time_stp),
        .b_left     (b_left)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Compared mid-cycle with DUT and model settled
    assert property (@(negedge clk) disable iff (reset) option_av == exp_out.av)
        else begin
            av_errors++;
            $display("[FAIL] %0t option_av %h, expected %h", $time, option_av, exp_out.av);
        end

    assert property (@(negedge clk) disable iff (reset) option_err == exp_out.err)
        else begin
            err_errors++;
            $display("[FAIL] %0t option_err %h, expected %h", $time, option_err, exp_out.err);
        end

    assert property (@(negedge clk) disable iff (reset) mss == exp_out.mss)
        else begin
            value_errors++;
            $display("[FAIL] %0t mss %h, expected %h", $time, mss, exp_out.mss);
        end

    assert property (@(negedge clk) disable iff (reset) scale_wnd == exp_out.scale)
        else begin
            value_errors++;
            $display("[FAIL] %0t scale_wnd %h, expected %h", $time, scale_wnd, exp_out.scale);
        end

    assert property (@(negedge clk) disable iff (reset) time_stp == exp_out.ts)
        else begin
            value_errors++;
            $display("[FAIL] %0t time_stp %h, expected %h", $time, time_stp, exp_out.ts);
        end

    assert property (@(negedge clk) disable iff (reset) b_left == exp_out.b_left)
        else begin
            left_errors++;
            $display("[FAIL] %0t b_left %0d, expected %0d", $time, b_left, exp_out.b_left);
        end

    task automatic apply_reset(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            reset <= 1'b1;
            data <= $urandom;
            pos <= 3'($urandom_range(7, 0));
            exp_out <= '0;
        end
        model = '0;
        frozen = 1'b0;
        @(posedge clk);
        reset <= 1'b0;
        data <= $urandom;
        pos <= 3'(4 + $urandom_range(3, 0));
        exp_out <= model;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

    initial begin
        int         total;
        logic [7:0] odd_kind;
        void'($urandom(35008));
        reset = 1'b1;
        data = '0;
        pos = 3'd4;
        model = '0;
        exp_out = '0;
        frozen = 1'b0;
        av_errors = 0;
        err_errors = 0;
        value_errors = 0;
        left_errors = 0;
        apply_reset(10);

        for (int p = 0; p < 4; p++) begin
            send_option(OPT_MSS, 8'd4, 4, p, {48'd0, 16'($urandom)});
            send_option(OPT_WSCALE, 8'd3, 3, p, {56'd0, 8'($urandom)});
            send_idle(1);
        end
        for (int p = 0; p < 4; p++) begin
            send_option(OPT_TSTAMP, 8'd10, 10, p, {$urandom, $urandom});
            send_idle(1);
        end
        for (int p = 0; p < 4; p++) begin
            send_option(OPT_SACK_OK, 8'd2, 2, p, 64'd0);
        end
        send_idle(1);

        // Bad length bytes still parse with the fixed length
        send_bad_length(OPT_MSS, 4, {48'd0, 16'($urandom)});
        send_idle(1);
        send_bad_length(OPT_WSCALE, 3, {56'd0, 8'($urandom)});
        send_idle(1);
        send_bad_length(OPT_SACK_OK, 2, 64'd0);
        send_idle(1);
        send_bad_length(OPT_TSTAMP, 10, {$urandom, $urandom});
        send_idle(1);

        // SACK blocks are not kept, so kind 5 is unknown
        send_unknown(8'd5, int'($urandom_range(3, 0)));
        send_option(OPT_MSS, 8'd4, 4, 0, {48'd0, 16'($urandom)});
        send_option(OPT_TSTAMP, 8'd10, 10, 1, {$urandom, $urandom});
        send_idle(2);
        apply_reset(10);

        odd_kind = 8'd0;
        while (odd_kind inside {8'd0, 8'd2, 8'd3, 8'd4, 8'd8}) begin
            odd_kind = 8'($urandom);
        end
        send_unknown(odd_kind, int'($urandom_range(3, 0)));
        send_option(OPT_WSCALE, 8'd3, 3, 1, {56'd0, 8'($urandom)});
        send_option(OPT_TSTAMP, 8'd10, 10, 2, {$urandom, $urandom});
        send_idle(2);
        apply_reset(10);

        send_option(OPT_EOL, 8'd0, 1, int'($urandom_range(3, 0)), 64'd0);
        send_option(OPT_MSS, 8'd4, 4, 0, {48'd0, 16'($urandom)});
        send_option(OPT_WSCALE, 8'd3, 3, 2, {56'd0, 8'($urandom)});
        send_idle(2);

        send_idle(3);
        @(negedge clk);
        total = av_errors + err_errors + value_errors + left_errors;
        $display("Errors: option_av %0d, option_err %0d, values %0d, b_left %0d, total %0d",
                 av_errors, err_errors, value_errors, left_errors, total);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== logic/tcp_opt_parser.sv ====
`timescale 1ns/10ps

module tcp_opt_parser
    import tcp_opt_pkg::*;
#(
    parameter int ACC_BYTES = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  word_t       data,
    input  logic [2:0]  pos,
    output opt_flags_t  option_av,
    output opt_flags_t  option_err,
    output logic [15:0] mss,
    output logic [7:0]  scale_wnd,
    output logic [63:0] time_stp,
    output logic [3:0]  b_left
);

    byte_take_t             take;
    len_check_t             check;
    opt_event_t             opt_event;
    logic                   unknown;
    logic [ACC_BYTES*8-1:0] field;

    tcp_opt_ctrl ctrl0 (
        .clk     (clk),
        .reset   (reset),
        .data    (data),
        .pos     (pos),
        .take    (take),
        .check   (check),
        .event_o (opt_event),
        .b_left  (b_left),
        .unknown (unknown)
    );

    opt_field_accum #(
        .ACC_BYTES (ACC_BYTES)
    ) accum0 (
        .clk   (clk),
        .reset (reset),
        .data  (data),
        .take  (take),
        .field (field)
    );

    opt_status_flags flags0 (
        .clk        (clk),
        .reset      (reset),
        .data       (data),
        .check      (check),
        .event_i    (opt_event),
        .unknown    (unknown),
        .option_av  (option_av),
        .option_err (option_err)
    );

    opt_value_regs #(
        .ACC_BYTES (ACC_BYTES)
    ) values0 (
        .clk       (clk),
        .reset     (reset),
        .field     (field),
        .event_i   (opt_event),
        .mss       (mss),
        .scale_wnd (scale_wnd),
        .time_stp  (time_stp)
    );

endmodule

// ==== logic/opt_value_regs.sv ====
`timescale 1ns/10ps

module opt_value_regs
    import tcp_opt_pkg::*;
#(
    parameter int ACC_BYTES = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [ACC_BYTES*8-1:0] field,
    input  opt_event_t             event_i,
    output logic [15:0]            mss,
    output logic [7:0]             scale_wnd,
    output logic [63:0]            time_stp
);

    always_ff @(posedge clk) begin
        if (reset) begin
            mss <= 16'd0;
            scale_wnd <= 8'd0;
            time_stp <= 64'd0;
        end else if (event_i.done) begin
            // Field already holds the last word's bytes
            case (event_i.kind)
                OPT_MSS:    mss <= field[15:0];
                OPT_WSCALE: scale_wnd <= field[7:0];
                OPT_TSTAMP: time_stp <= field[63:0];
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== logic/opt_status_flags.sv ====
`timescale 1ns/10ps

module opt_status_flags
    import tcp_opt_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  word_t      data,
    input  len_check_t check,
    input  opt_event_t event_i,
    input  logic       unknown,
    output opt_flags_t option_av,
    output opt_flags_t option_err
);

    logic [7:0] len_byte;
    logic       len_bad;

    assign len_byte = data[8*(3 - check.lane) +: 8];
    assign len_bad = check.valid && (len_byte != {4'd0, opt_len(check.kind)});

    always_ff @(posedge clk) begin
        if (reset) begin
            option_av <= '0;
            option_err <= '0;
        end else begin
            if (event_i.start) begin
                option_av[4'(event_i.kind)] <= 1'b1;
            end
            // Unknown kind poisons every error bit
            if (unknown) begin
                option_err <= '1;
            end else if (len_bad) begin
                option_err[4'(check.kind)] <= 1'b1;
            end
        end
    end

    // End-of-list has no length byte to check
    assert property (@(posedge clk) disable iff (reset)
        check.valid |-> check.kind inside {OPT_MSS, OPT_WSCALE, OPT_SACK_OK, OPT_TSTAMP});

endmodule

// ==== logic/opt_field_accum.sv ====
`timescale 1ns/10ps

module opt_field_accum
    import tcp_opt_pkg::*;
#(
    parameter int ACC_BYTES = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  word_t                  data,
    input  byte_take_t             take,
    output logic [ACC_BYTES*8-1:0] field
);

    logic [ACC_BYTES*8-1:0] acc;
    logic [ACC_BYTES*8-1:0] acc_nxt;

    // Selected lanes enter at the bottom, earlier bytes move up
    always_comb begin
        acc_nxt = acc;
        if (take.valid) begin
            if (take.first) begin
                acc_nxt = '0;
            end
            for (int i = 0; i < 4; i++) begin
                if (i >= int'(take.lane) && i < int'(take.lane) + int'(take.count)) begin
                    acc_nxt = {acc_nxt[ACC_BYTES*8-9:0], data[8*(3 - i) +: 8]};
                end
            end
        end
    end

    assign field = acc_nxt;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else begin
            acc <= acc_nxt;
        end
    end

    // Control never reaches past the last lane
    assert property (@(posedge clk) disable iff (reset)
        take.valid |-> int'(take.lane) + int'(take.count) <= 4);

endmodule

// ==== logic/tcp_opt_ctrl.sv ====
`timescale 1ns/10ps

module tcp_opt_ctrl
    import tcp_opt_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  word_t      data,
    input  logic [2:0] pos,
    output byte_take_t take,
    output len_check_t check,
    output opt_event_t event_o,
    output logic [3:0] b_left,
    output logic       unknown
);

    parser_state_e state, state_nxt;
    opt_kind_e     cur_kind, kind_nxt, new_kind;
    logic [3:0]    b_left_nxt;
    lane_t         p;
    lane_t         v_lane;
    logic [7:0]    kind_byte;
    logic          known;
    logic [3:0]    len;
    logic [3:0]    head;
    logic [3:0]    room;
    logic [3:0]    idx;
    logic [3:0]    n;

    assign p = pos[1:0];
    assign kind_byte = data[8*(3 - p) +: 8];
    assign new_kind = opt_kind_e'(kind_byte);

    always_comb begin
        case (kind_byte)
            OPT_EOL, OPT_MSS, OPT_WSCALE, OPT_SACK_OK, OPT_TSTAMP: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        state_nxt = state;
        kind_nxt = cur_kind;
        b_left_nxt = b_left;
        take = '0;
        check = '0;
        event_o = '0;
        check.kind = cur_kind;
        event_o.kind = cur_kind;
        len = opt_len(cur_kind);
        head = 4'd4 - {2'b00, p};
        room = 4'd0;
        v_lane = 2'd0;
        idx = 4'd0;
        n = 4'd0;
        case (state)
            IDLE: begin
                if (!pos[2]) begin
                    if (!known) begin
                        state_nxt = UNKNOWN;
                    end else if (new_kind == OPT_EOL) begin
                        kind_nxt = new_kind;
                        event_o.start = 1'b1;
                        event_o.done = 1'b1;
                        event_o.kind = new_kind;
                        state_nxt = END_OF_LIST;
                    end else begin
                        len = opt_len(new_kind);
                        kind_nxt = new_kind;
                        event_o.start = 1'b1;
                        event_o.kind = new_kind;
                        // Length byte in this word unless kind sits in lane 3
                        check.valid = (p != 2'd3);
                        check.kind = new_kind;
                        check.lane = p + 2'd1;
                        take.valid = 1'b1;
                        take.first = 1'b1;
                        if (p < 2'd2) begin
                            room = head - 4'd2;
                            take.lane = p + 2'd2;
                            take.count = (len - 4'd2 < room) ? 3'(len - 4'd2) : 3'(room);
                        end
                        if (len > head) begin
                            b_left_nxt = len - head;
                            state_nxt = IN_OPTION;
                        end else begin
                            b_left_nxt = 4'd0;
                            event_o.done = 1'b1;
                        end
                    end
                end
            end
            IN_OPTION: begin
                // Option byte index found at lane 0
                idx = len - b_left;
                check.valid = (idx == 4'd1);
                check.lane = 2'd0;
                v_lane = (idx == 4'd1) ? 2'd1 : 2'd0;
                n = (b_left > 4'd4) ? 4'd4 : b_left;
                take.valid = 1'b1;
                take.lane = v_lane;
                take.count = 3'(n - {2'b00, v_lane});
                if (b_left > 4'd4) begin
                    b_left_nxt = b_left - 4'd4;
                end else begin
                    b_left_nxt = 4'd0;
                    event_o.done = 1'b1;
                    state_nxt = IDLE;
                end
            end
            default: begin
            end
        endcase
    end

    // High in the word that holds the unknown kind and from then on
    assign unknown = (state_nxt == UNKNOWN);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            cur_kind <= OPT_EOL;
            b_left <= 4'd0;
        end else begin
            state <= state_nxt;
            cur_kind <= kind_nxt;
            b_left <= b_left_nxt;
        end
    end

    assert property (@(posedge clk) disable iff (reset) take.count <= 3'd4);

    assert property (@(posedge clk) disable iff (reset) b_left <= 4'(MAX_OPT_LEN - 1));

endmodule

// ==== logic/tcp_opt_pkg.sv ====
package tcp_opt_pkg;

    typedef logic [31:0] word_t;
    typedef logic [1:0] lane_t;
    typedef logic [8:0] opt_flags_t;

    typedef enum logic [7:0] {
        OPT_EOL     = 8'd0,
        OPT_MSS     = 8'd2,
        OPT_WSCALE  = 8'd3,
        OPT_SACK_OK = 8'd4,
        OPT_TSTAMP  = 8'd8
    } opt_kind_e;

    typedef enum logic [1:0] {
        IDLE,
        IN_OPTION,
        END_OF_LIST,
        UNKNOWN
    } parser_state_e;

    // Value bytes handed from control to the accumulator
    typedef struct packed {
        logic       valid;
        logic       first;
        lane_t      lane;
        logic [2:0] count;
    } byte_take_t;

    typedef struct packed {
        logic      valid;
        opt_kind_e kind;
        lane_t     lane;
    } len_check_t;

    typedef struct packed {
        logic      start;
        logic      done;
        opt_kind_e kind;
    } opt_event_t;

    localparam int unsigned MAX_OPT_LEN = 10;

    localparam logic [3:0] OPT_LEN_EOL     = 4'd1;
    localparam logic [3:0] OPT_LEN_MSS     = 4'd4;
    localparam logic [3:0] OPT_LEN_WSCALE  = 4'd3;
    localparam logic [3:0] OPT_LEN_SACK_OK = 4'd2;
    localparam logic [3:0] OPT_LEN_TSTAMP  = 4'(MAX_OPT_LEN);

    function automatic logic [3:0] opt_len(opt_kind_e kind);
        case (kind)
            OPT_EOL:     return OPT_LEN_EOL;
            OPT_MSS:     return OPT_LEN_MSS;
            OPT_WSCALE:  return OPT_LEN_WSCALE;
            OPT_SACK_OK: return OPT_LEN_SACK_OK;
            OPT_TSTAMP:  return OPT_LEN_TSTAMP;
            default:     return 4'd0;
        endcase
    endfunction

endpackage
